/* rtl/cam_cfg_pkg.sv */
// cam sizing constants
// key width, request address and index widths, default bank geometry
// shared by the tag store RTL and its testbench

`default_nettype none

package cam_cfg_pkg;

    //////////////////////////////////////////////////////////////////////
    // field widths
    //////////////////////////////////////////////////////////////////////

    localparam int unsigned KEY_W  = 16;  // stored key / lookup key
    localparam int unsigned ADDR_W = 8;   // request entry address
    localparam int unsigned IDX_W  = 8;   // result index, bank bit included

    //////////////////////////////////////////////////////////////////////
    // defaults for the top level
    //////////////////////////////////////////////////////////////////////

    // entries in each of the two banks
    localparam int unsigned ENTRIES_DEF = 8;

    // encoder style, 0 selects the table form
    localparam int unsigned IMPL_DEF = 0;

endpackage : cam_cfg_pkg

`default_nettype wire

/* rtl/cam_cmd_pkg.sv */
// cam command and result types
// opcode enum, request word, per-bank lookup result, merged response
// all structs are packed so they travel as plain vectors

`default_nettype none

package cam_cmd_pkg;

    //////////////////////////////////////////////////////////////////////
    // request side
    //////////////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        OP_NOP    = 2'd0,  // no effect
        OP_WRITE  = 2'd1,  // store key, set valid
        OP_INVAL  = 2'd2,  // clear valid
        OP_LOOKUP = 2'd3   // search both banks
    } cam_op_e;

    // low addr bits pick the entry, next bit picks the bank
    typedef struct packed {
        cam_op_e                          op;
        logic [cam_cfg_pkg::ADDR_W-1:0]   addr;
        logic [cam_cfg_pkg::KEY_W-1:0]    key;
    } cam_req_t;

    //////////////////////////////////////////////////////////////////////
    // result side
    //////////////////////////////////////////////////////////////////////

    // one bank, one cycle after the lookup
    typedef struct packed {
        logic                             vld;    // lookup result present
        logic                             hit;    // some valid entry matched
        logic                             multi;  // two or more matched
        logic [cam_cfg_pkg::IDX_W-1:0]    idx;    // entry number, upper bits zero
    } cam_bank_res_t;

    // merged, bank bit inserted above the entry number
    typedef struct packed {
        logic                             hit;
        logic                             multi;
        logic [cam_cfg_pkg::IDX_W-1:0]    idx;
    } cam_rsp_t;

endpackage : cam_cmd_pkg

`default_nettype wire

/* rtl/oht2bin_base.sv */
// one-hot to binary encoder
// purely combinational, three selectable structures
// several set bits give the OR of their positions, no priority

`default_nettype none
`timescale 1ns/1ns

module oht2bin_base #(
    parameter  int unsigned WIDTH          = 32,
    localparam int unsigned WIDTH_LOG      = $clog2(WIDTH),
    // 0 selects mask table, 1 selects masked loop, 2 selects conditional loop
    parameter  int unsigned IMPLEMENTATION = 0
)(
    input  logic [WIDTH-1:0]     oht,  // one-hot vector
    output logic [WIDTH_LOG-1:0] bin,  // encoded position
    output logic                 vld   // any bit set
);

    // positions whose binary form has bit b set
    function automatic logic [WIDTH-1:0] mask_f(int unsigned b);
        logic [WIDTH-1:0] m;
        m = '0;
        for (int unsigned j = 0; j < WIDTH; j++) begin
            m[j] = j[b];
        end
        return m;
    endfunction : mask_f

    //////////////////////////////////////////////////////////////////////
    // structure select
    //////////////////////////////////////////////////////////////////////

    generate
        case (IMPLEMENTATION)
            0: begin : g_table
                // one wide OR per output bit
                for (genvar b = 0; b < WIDTH_LOG; b++) begin : g_bit
                    localparam logic [WIDTH-1:0] MASK = mask_f(b);
                    assign bin[b] = |(oht & MASK);
                end
                assign vld = |oht;
            end
            1: begin : g_loop_all
                always_comb begin
                    bin = '0;
                    for (int unsigned i = 0; i < WIDTH; i++) begin
                        // replicate the input bit as a position mask
                        bin = bin | ({WIDTH_LOG{oht[i]}} & WIDTH_LOG'(i));
                    end
                end
                assign vld = |oht;
            end
            2: begin : g_loop_ones
                always_comb begin
                    bin = '0;
                    for (int unsigned i = 0; i < WIDTH; i++) begin
                        if (oht[i]) begin
                            bin = bin | WIDTH_LOG'(i);  // OR keeps it flat
                        end
                    end
                end
                assign vld = |oht;
            end
            default: begin : g_bad_impl
                $fatal(1, "oht2bin_base: IMPLEMENTATION %0d is not supported",
                       IMPLEMENTATION);
            end
        endcase
    endgenerate

endmodule : oht2bin_base

`default_nettype wire

/* rtl/cam_bank.sv */
// cam bank
// key registers with valid bits, selected write and invalidate,
// parallel compare of all entries, registered encoded match result

`default_nettype none
`timescale 1ns/1ns

module cam_bank #(
    parameter int unsigned ENTRIES        = 8,
    parameter int unsigned IMPLEMENTATION = 0
)(
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       req_vld,  // one-cycle strobe
    input  logic                       sel,      // address points at this bank
    input  cam_cmd_pkg::cam_req_t      req,
    output cam_cmd_pkg::cam_bank_res_t res
);

    import cam_cfg_pkg::*;
    import cam_cmd_pkg::*;

    localparam int unsigned ENT_W = $clog2(ENTRIES);

    logic [KEY_W-1:0]   key_mem [ENTRIES];  // stored keys
    logic [ENTRIES-1:0] valid;              // entry holds a key
    logic [ENT_W-1:0]   ent;                // addressed entry
    logic               do_wr;
    logic               do_inv;
    logic               do_lkp;

    logic [ENTRIES-1:0] match;    // one-hot if keys are unique
    logic [ENT_W-1:0]   enc_bin;
    logic               enc_vld;
    logic               many;     // more than one match

    logic               res_vld_q;
    logic               res_hit_q;
    logic               res_multi_q;
    logic [ENT_W-1:0]   res_ent_q;

    //////////////////////////////////////////////////////////////////////
    // request decode and storage
    //////////////////////////////////////////////////////////////////////

    assign ent    = req.addr[ENT_W-1:0];
    assign do_wr  = req_vld && sel && (req.op == OP_WRITE);
    assign do_inv = req_vld && sel && (req.op == OP_INVAL);
    assign do_lkp = req_vld && (req.op == OP_LOOKUP);  // bank select ignored

    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= '0;
        end else if (do_wr) begin
            valid[ent] <= 1'b1;
        end else if (do_inv) begin
            valid[ent] <= 1'b0;
        end
    end

    // key only changes on a write, invalidate leaves it stale
    always_ff @(posedge clk) begin
        if (do_wr) begin
            key_mem[ent] <= req.key;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // compare and encode
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        for (int unsigned i = 0; i < ENTRIES; i++) begin
            match[i] = valid[i] && (key_mem[i] == req.key);
        end
    end

    assign many = ($countones(match) > 1);

    oht2bin_base #(
        .WIDTH          (ENTRIES),
        .IMPLEMENTATION (IMPLEMENTATION)
    ) u_enc (
        .oht (match),
        .bin (enc_bin),
        .vld (enc_vld)
    );

    // result strobe
    always_ff @(posedge clk) begin
        if (rst) begin
            res_vld_q <= 1'b0;
        end else begin
            res_vld_q <= do_lkp;
        end
    end

    // payload held between lookups
    always_ff @(posedge clk) begin
        if (do_lkp) begin
            res_hit_q   <= enc_vld;
            res_multi_q <= many;
            res_ent_q   <= enc_bin;
        end
    end

    always_comb begin
        res.vld   = res_vld_q;
        res.hit   = res_hit_q;
        res.multi = res_multi_q;
        res.idx   = IDX_W'(res_ent_q);  // upper bits zero
    end

    //////////////////////////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////////////////////////

    // a single hit names a valid entry that holds the looked-up key
    a_hit_entry : assert property (@(posedge clk) disable iff (rst)
        (res.vld && res.hit && !res.multi) |->
            (valid[res_ent_q] && (key_mem[res_ent_q] == $past(req.key))));

    // several matches always come with the encoder's any-bit flag
    a_multi_is_hit : assert property (@(posedge clk) disable iff (rst)
        (res.vld && res.multi) |-> res.hit);

endmodule : cam_bank

`default_nettype wire

/* rtl/cam_hit_merge.sv */
// cam hit merge
// combines the two bank results into one registered response,
// bank 0 wins, bank bit goes above the entry number

`default_nettype none
`timescale 1ns/1ns

module cam_hit_merge #(
    parameter int unsigned ENTRIES = 8
)(
    input  logic                       clk,
    input  logic                       rst,
    input  cam_cmd_pkg::cam_bank_res_t res0,  // bank 0
    input  cam_cmd_pkg::cam_bank_res_t res1,  // bank 1
    output logic                       rsp_vld,
    output cam_cmd_pkg::cam_rsp_t      rsp
);

    import cam_cfg_pkg::*;
    import cam_cmd_pkg::*;

    localparam int unsigned      ENT_W = $clog2(ENTRIES);
    localparam logic [IDX_W-1:0] BANK1 = IDX_W'(1) << ENT_W;  // bank bit set

    cam_rsp_t rsp_nxt;

    //////////////////////////////////////////////////////////////////////
    // response rule
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        rsp_nxt.hit   = res0.hit | res1.hit;
        // several in one bank, or one in each
        rsp_nxt.multi = res0.multi | res1.multi | (res0.hit & res1.hit);
        if (res0.hit) begin
            rsp_nxt.idx = res0.idx;          // bank bit stays 0
        end else if (res1.hit) begin
            rsp_nxt.idx = res1.idx | BANK1;
        end else begin
            rsp_nxt.idx = '0;                // miss
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rsp_vld <= 1'b0;
        end else begin
            rsp_vld <= res0.vld;  // banks in lockstep
        end
    end

    always_ff @(posedge clk) begin
        if (res0.vld) begin
            rsp <= rsp_nxt;
        end
    end

    // both banks see every lookup, so their strobes never differ
    a_banks_lockstep : assert property (@(posedge clk) disable iff (rst)
        res0.vld == res1.vld);

endmodule : cam_hit_merge

`default_nettype wire

/* rtl/cam_top.sv */
// cam top
// two-bank tag store, request broadcast to both banks,
// bank select from the address, merged response two cycles after a lookup

`default_nettype none
`timescale 1ns/1ns

module cam_top #(
    parameter int unsigned ENTRIES        = cam_cfg_pkg::ENTRIES_DEF,
    parameter int unsigned IMPLEMENTATION = cam_cfg_pkg::IMPL_DEF
)(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  req_vld,
    input  cam_cmd_pkg::cam_req_t req,
    output logic                  rsp_vld,
    output cam_cmd_pkg::cam_rsp_t rsp
);

    import cam_cfg_pkg::*;
    import cam_cmd_pkg::*;

    localparam int unsigned ENT_W = $clog2(ENTRIES);

    // both banks plus the bank bit must fit in the address field
    if ((ENTRIES != (1 << ENT_W)) || ((2 * ENTRIES) > (1 << ADDR_W))) begin : g_bad_size
        $fatal(1, "cam_top: ENTRIES %0d unusable", ENTRIES);
    end

    logic          bank_bit;
    logic          sel0;
    logic          sel1;
    cam_bank_res_t res0;
    cam_bank_res_t res1;

    assign bank_bit = req.addr[ENT_W];
    assign sel0     = ~bank_bit;
    assign sel1     = bank_bit;

    //////////////////////////////////////////////////////////////////////
    // banks and merge
    //////////////////////////////////////////////////////////////////////

    cam_bank #(
        .ENTRIES        (ENTRIES),
        .IMPLEMENTATION (IMPLEMENTATION)
    ) u_bank0 (
        .clk     (clk),
        .rst     (rst),
        .req_vld (req_vld),
        .sel     (sel0),
        .req     (req),
        .res     (res0)
    );

    cam_bank #(
        .ENTRIES        (ENTRIES),
        .IMPLEMENTATION (IMPLEMENTATION)
    ) u_bank1 (
        .clk     (clk),
        .rst     (rst),
        .req_vld (req_vld),
        .sel     (sel1),
        .req     (req),
        .res     (res1)
    );

    cam_hit_merge #(
        .ENTRIES (ENTRIES)
    ) u_merge (
        .clk     (clk),
        .rst     (rst),
        .res0    (res0),
        .res1    (res1),
        .rsp_vld (rsp_vld),
        .rsp     (rsp)
    );

    // end to end latency through bank and merge registers
    a_lookup_rsp : assert property (@(posedge clk) disable iff (rst)
        (req_vld && (req.op == OP_LOOKUP)) |-> ##2 rsp_vld);

endmodule : cam_top

`default_nettype wire

/* dv/cam_tb.sv */
// cam testbench
// directed operations from a data file, then an xorshift random run
// every response is checked against a reference model of both banks

`default_nettype none
`timescale 1ns/1ns

module cam_tb;

    import cam_cfg_pkg::*;
    import cam_cmd_pkg::*;

    localparam int unsigned ENTRIES  = ENTRIES_DEF;
    localparam int unsigned TOTAL    = 2 * ENTRIES;  // both banks
    localparam int unsigned RAND_OPS = 200;
    localparam int unsigned WAIT_MAX = 16;           // cycle limit for any wait

    // one outstanding lookup
    typedef struct packed {
        logic [31:0] due;  // falling edge where rsp_vld is expected
        cam_rsp_t    rsp;
    } exp_t;

    logic     clk = 1'b0;
    logic     rst;
    logic     req_vld;
    cam_req_t req;
    logic     rsp_vld;
    cam_rsp_t rsp;

    logic [KEY_W-1:0] mkey [TOTAL];  // model keys, bank 1 in the upper half
    logic [TOTAL-1:0] mvalid;        // model valid bits
    exp_t             exp_q [$];     // in request order
    int unsigned      cyc;           // falling edges seen
    logic             chk_on;        // response checking active
    logic [31:0]      rnd;           // xorshift state

    always #4 clk = ~clk;  // 8 ns period

    cam_top #(
        .ENTRIES        (ENTRIES),
        .IMPLEMENTATION (IMPL_DEF)
    ) u_dut (
        .clk     (clk),
        .rst     (rst),
        .req_vld (req_vld),
        .req     (req),
        .rsp_vld (rsp_vld),
        .rsp     (rsp)
    );

    //////////////////////////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////////////////////////

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("Fail %s got %h exp %h", name, got, exp));
        end
    endtask

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // response rule: bank 0 wins, bank bit above entry number,
    // several matches in one bank give the OR of their entry numbers
    function automatic cam_rsp_t model_lookup(input logic [KEY_W-1:0] key);
        cam_rsp_t         r;
        logic [IDX_W-1:0] or0;
        logic [IDX_W-1:0] or1;
        logic             hit0;
        logic             hit1;
        int unsigned      nmatch;
        or0    = '0;
        or1    = '0;
        hit0   = 1'b0;
        hit1   = 1'b0;
        nmatch = 0;
        for (int unsigned g = 0; g < TOTAL; g++) begin
            if (mvalid[g] && (mkey[g] == key)) begin
                nmatch++;
                if (g < ENTRIES) begin
                    hit0 = 1'b1;
                    or0  = or0 | IDX_W'(g);
                end else begin
                    hit1 = 1'b1;
                    or1  = or1 | IDX_W'(g - ENTRIES);
                end
            end
        end
        r.hit   = hit0 | hit1;
        r.multi = (nmatch > 1);  // counted over both banks
        if (hit0) begin
            r.idx = or0;
        end else if (hit1) begin
            r.idx = or1 | IDX_W'(ENTRIES);  // bank bit
        end else begin
            r.idx = '0;
        end
        return r;
    endfunction

    // advance to the next falling edge and check the response strobe there
    task automatic step();
        exp_t e;
        @(negedge clk);
        cyc++;
        if (chk_on) begin
            if ((exp_q.size() != 0) && (exp_q[0].due == cyc)) begin
                e = exp_q.pop_front();
                check("rsp_vld", rsp_vld, 1'b1);
                check("rsp.hit", rsp.hit, e.rsp.hit);
                check("rsp.multi", rsp.multi, e.rsp.multi);
                check("rsp.idx", rsp.idx, e.rsp.idx);
            end else begin
                check("rsp_vld", rsp_vld, 1'b0);  // nothing due this cycle
            end
        end
    endtask

    // one request strobe, model updated in issue order
    task automatic issue(input cam_op_e op, input logic [ADDR_W-1:0] addr,
                         input logic [KEY_W-1:0] key, output cam_rsp_t want);
        int unsigned g;
        exp_t        e;
        step();
        req_vld  = 1'b1;
        req.op   = op;
        req.addr = addr;
        req.key  = key;
        g        = addr % TOTAL;  // bank bit and entry
        want     = '0;
        case (op)
            OP_WRITE: begin
                mkey[g]   = key;
                mvalid[g] = 1'b1;
            end
            OP_INVAL: begin
                mvalid[g] = 1'b0;  // key stays
            end
            OP_LOOKUP: begin
                want  = model_lookup(key);
                e.due = cyc + 2;   // two clock edges later
                e.rsp = want;
                exp_q.push_back(e);
            end
            default: begin
            end
        endcase
    endtask

    task automatic idle(input int unsigned n);
        repeat (n) begin
            step();
            req_vld = 1'b0;
            req     = '0;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // test sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        int               fd;
        int               n;
        int unsigned      nlines;
        int unsigned      t;
        string            line;
        logic [31:0]      f_op;
        logic [31:0]      f_addr;
        logic [31:0]      f_key;
        logic [31:0]      f_hit;
        logic [31:0]      f_multi;
        logic [31:0]      f_idx;
        logic [ADDR_W-1:0] r_addr;
        logic [KEY_W-1:0] r_key;
        logic [2:0]       kind;
        cam_rsp_t         want;

        rst     = 1'b1;
        req_vld = 1'b0;
        req     = '0;
        cyc     = 0;
        chk_on  = 1'b0;
        rnd     = 32'h1d95;
        mvalid  = '0;
        nlines  = 0;
        for (int unsigned i = 0; i < TOTAL; i++) begin
            mkey[i] = '0;
        end

        repeat (4) step();  // reset over 4 rising edges
        rst = 1'b0;

        t = 0;
        while (rsp_vld !== 1'b0) begin
            if (t >= WAIT_MAX) begin
                abort_run("response strobe did not settle low after reset");
            end else begin
                step();
                t++;
            end
        end
        chk_on = 1'b1;
        idle(6);  // quiet store, strobe must stay low

        // directed operations, one per cycle
        fd = $fopen("dv/cam_tests.txt", "r");
        if (fd == 0) begin
            abort_run("could not open the directed test file dv/cam_tests.txt");
        end
        while ($fgets(line, fd) != 0) begin
            if ((line.len() < 2) || (line[0] == "#")) begin
                continue;
            end
            n = $sscanf(line, "%h %h %h %h %h %h",
                        f_op, f_addr, f_key, f_hit, f_multi, f_idx);
            if (n != 6) begin
                abort_run("a line of the directed test file has too few columns");
            end
            issue(cam_op_e'(f_op[1:0]), f_addr[ADDR_W-1:0], f_key[KEY_W-1:0], want);
            if (f_op == OP_LOOKUP) begin
                // data file against model
                check("file_hit", f_hit, want.hit);
                check("file_multi", f_multi, want.multi);
                check("file_idx", f_idx, want.idx);
            end
            nlines++;
        end
        $fclose(fd);
        if (nlines == 0) begin
            abort_run("the directed test file holds no operations");
        end

        // random mix, keys mostly taken from the model
        for (int unsigned i = 0; i < RAND_OPS; i++) begin
            rnd    = xorshift(rnd);
            r_addr = ADDR_W'(rnd[15:8] % TOTAL);
            if (rnd[17:16] != 2'b00) begin
                r_key = mkey[rnd[23:20] % TOTAL];
            end else begin
                r_key = 16'h5a00 | KEY_W'(rnd[27:24]);  // small pool, many repeats
            end
            kind = rnd[30:28];
            if (kind < 3'd4) begin
                issue(OP_LOOKUP, r_addr, r_key, want);
            end else if (kind < 3'd6) begin
                issue(OP_WRITE, r_addr, r_key, want);
            end else if (kind == 3'd6) begin
                issue(OP_INVAL, r_addr, r_key, want);
            end else begin
                idle(1);
            end
        end

        // drain the last lookups
        t = 0;
        while (exp_q.size() != 0) begin
            if (t >= WAIT_MAX) begin
                abort_run("lookup responses still missing at the end of the run");
            end else begin
                idle(1);
                t++;
            end
        end
        idle(4);  // no stray strobes

        $display("=== PASS ===");
        $finish;
    end

endmodule : cam_tb

`default_nettype wire

/* dv/cam_tests.txt */
# op(0 nop, 1 write, 2 inval, 3 lookup) addr key exp_hit exp_multi exp_idx, all hex
# addr bit 3 picks bank 1; expected columns are zero for ops other than lookup
3 00 1234 0 0 00
3 0f ffff 0 0 00
0 00 0000 0 0 00
1 03 abcd 0 0 00
3 00 abcd 1 0 03
1 0d 1357 0 0 00
3 00 1357 1 0 0d
3 00 abcd 1 0 03
2 03 0000 0 0 00
3 00 abcd 0 0 00
3 00 1357 1 0 0d
1 01 2468 0 0 00
1 0a 2468 0 0 00
3 00 2468 1 1 01
1 05 7777 0 0 00
1 06 7777 0 0 00
3 00 7777 1 1 07
1 0c 9999 0 0 00
1 0b 9999 0 0 00
3 00 9999 1 1 0f
3 0f 9999 1 1 0f
2 01 0000 0 0 00
3 00 2468 1 0 0a
3 00 7777 1 1 07
2 0a 0000 0 0 00
3 00 2468 0 0 00
1 03 abcd 0 0 00
3 00 abcd 1 0 03
1 03 bcde 0 0 00
3 00 abcd 0 0 00
3 00 bcde 1 0 03
0 00 0000 0 0 00
3 00 1357 1 0 0d
2 0d 0000 0 0 00
3 00 1357 0 0 00
1 08 0000 0 0 00
3 00 0000 1 0 08

/* vlog.f */
rtl/cam_cfg_pkg.sv
rtl/cam_cmd_pkg.sv
rtl/oht2bin_base.sv
rtl/cam_bank.sv
rtl/cam_hit_merge.sv
rtl/cam_top.sv
dv/cam_tb.sv
